/* mipsPkg.sv */
`default_nettype none

package mipsPkg;

	////////////////////////////////////////////////////////////////////////////
	// Width types
	////////////////////////////////////////////////////////////////////////////
	typedef logic [31:0] wordT;      // Data or instruction word
	typedef logic [4:0]  regAddrT;   // Register number
	typedef logic [5:0]  opcodeT;    // Primary opcode field
	typedef logic [5:0]  functT;     // R-type function field
	typedef logic [3:0]  aluOpT;     // ALU operation code
	typedef logic [1:0]  aluSrcT;    // Operand B and shift source
	typedef logic [3:0]  byteMaskT;  // Byte lanes of an access
	typedef logic [4:0]  shamtT;     // Shift amount

	////////////////////////////////////////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////////////////////////////////////////
	localparam opcodeT OP_RTYPE = 6'b000000;
	localparam opcodeT OP_BEQ   = 6'b000100;
	localparam opcodeT OP_BNE   = 6'b000101;
	localparam opcodeT OP_ADDI  = 6'b001000;
	localparam opcodeT OP_SLTI  = 6'b001010;
	localparam opcodeT OP_ANDI  = 6'b001100;
	localparam opcodeT OP_ORI   = 6'b001101;
	localparam opcodeT OP_XORI  = 6'b001110;
	localparam opcodeT OP_LUI   = 6'b001111;
	localparam opcodeT OP_LB    = 6'b100000;  // Low two bits give the size
	localparam opcodeT OP_LH    = 6'b100001;
	localparam opcodeT OP_LW    = 6'b100011;
	localparam opcodeT OP_LBU   = 6'b100100;  // Bit 2 marks unsigned loads
	localparam opcodeT OP_LHU   = 6'b100101;
	localparam opcodeT OP_LWU   = 6'b100111;
	localparam opcodeT OP_SB    = 6'b101000;
	localparam opcodeT OP_SH    = 6'b101001;
	localparam opcodeT OP_SW    = 6'b101011;

	localparam functT FN_SLL  = 6'b000000;
	localparam functT FN_SRL  = 6'b000010;
	localparam functT FN_SRA  = 6'b000011;
	localparam functT FN_SLLV = 6'b000100;
	localparam functT FN_SRLV = 6'b000110;
	localparam functT FN_SRAV = 6'b000111;
	localparam functT FN_ADD  = 6'b100000;
	localparam functT FN_SUB  = 6'b100010;
	localparam functT FN_AND  = 6'b100100;
	localparam functT FN_OR   = 6'b100101;
	localparam functT FN_XOR  = 6'b100110;
	localparam functT FN_NOR  = 6'b100111;
	localparam functT FN_SLT  = 6'b101010;

	////////////////////////////////////////////////////////////////////////////
	// ALU codes, operand selects, lane masks and memory size
	////////////////////////////////////////////////////////////////////////////
	localparam aluOpT ALU_ADD = 4'b0000;
	localparam aluOpT ALU_SUB = 4'b0001;
	localparam aluOpT ALU_AND = 4'b0010;
	localparam aluOpT ALU_OR  = 4'b0011;
	localparam aluOpT ALU_XOR = 4'b0100;
	localparam aluOpT ALU_NOR = 4'b0101;
	localparam aluOpT ALU_SLL = 4'b0110;
	localparam aluOpT ALU_SRL = 4'b0111;
	localparam aluOpT ALU_SRA = 4'b1000;
	localparam aluOpT ALU_SLT = 4'b1001;  // Highest defined code

	localparam aluSrcT SRC_REG      = 2'b00;  // Bit 0 picks the immediate
	localparam aluSrcT SRC_IMM      = 2'b01;
	localparam aluSrcT SRC_SHAMT    = 2'b10;  // Bit 1 picks the shamt field
	localparam aluSrcT SRC_IMMSHAMT = 2'b11;

	localparam byteMaskT BYTES_B = 4'b0001;
	localparam byteMaskT BYTES_H = 4'b0011;
	localparam byteMaskT BYTES_W = 4'b1111;

	localparam int MEM_WORDS     = 64;
	localparam int MEM_ADDR_BITS = 6;

endpackage

`default_nettype wire

/* controlDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module controlDecode (
	input wire clk,
	input wire rst,
	input wire instrValid,                  // Instruction strobe
	input wire mipsPkg::wordT instr,        // Instruction word
	output mipsPkg::aluOpT aluOp,
	output mipsPkg::aluSrcT aluSrc,
	output logic regWrite,
	output logic memToReg,
	output logic memWrite,
	output logic branch,
	output logic branchNe,
	output logic loadUnsigned,
	output mipsPkg::byteMaskT readBytes,
	output mipsPkg::byteMaskT writeBytes,
	output mipsPkg::regAddrT destReg,
	output mipsPkg::wordT immVal,
	output mipsPkg::shamtT shamt
);

	mipsPkg::opcodeT opcode;                // Instruction fields
	mipsPkg::functT funct;
	mipsPkg::regAddrT rtField;
	mipsPkg::regAddrT rdField;
	logic [15:0] immField;

	logic known;                            // Opcode and funct recognised
	logic useRd;                            // R-type writes rd
	logic zeroExt;                          // Logic immediates
	logic isLui;                            // Upper immediate shift
	mipsPkg::aluOpT nAluOp;                 // Next control levels
	mipsPkg::aluSrcT nAluSrc;
	logic nRegWrite;
	logic nMemToReg;
	logic nMemWrite;
	logic nBranch;
	logic nBranchNe;
	logic nLoadUnsigned;
	mipsPkg::byteMaskT nReadBytes;
	mipsPkg::byteMaskT nWriteBytes;
	mipsPkg::regAddrT nDest;

	// Access size from the low opcode bits of loads and stores
	function automatic mipsPkg::byteMaskT sizeMask(input logic [1:0] sizeBits);
		case (sizeBits)
			2'b00: sizeMask = mipsPkg::BYTES_B;
			2'b01: sizeMask = mipsPkg::BYTES_H;
			default: sizeMask = mipsPkg::BYTES_W;
		endcase
	endfunction

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rtField = instr[20:16];
	assign rdField = instr[15:11];
	assign immField = instr[15:0];
	assign nDest = useRd ? rdField : rtField;

	////////////////////////////////////////////////////////////////////////////
	// Opcode and funct decode
	////////////////////////////////////////////////////////////////////////////
	always_comb
	begin
		known = 1'b1;
		useRd = 1'b0;
		zeroExt = 1'b0;
		isLui = 1'b0;
		nAluOp = mipsPkg::ALU_ADD;              // Address and ADDI sum
		nAluSrc = mipsPkg::SRC_IMM;
		nRegWrite = 1'b1;
		nMemToReg = 1'b0;
		nMemWrite = 1'b0;
		nBranch = 1'b0;
		nBranchNe = 1'b0;
		nLoadUnsigned = 1'b0;
		nReadBytes = mipsPkg::BYTES_W;
		nWriteBytes = mipsPkg::BYTES_W;
		case (opcode)
			mipsPkg::OP_RTYPE:
			begin
				useRd = 1'b1;
				nAluSrc = mipsPkg::SRC_REG;        // Variable shifts use rs
				case (funct)
					mipsPkg::FN_ADD: nAluOp = mipsPkg::ALU_ADD;
					mipsPkg::FN_SUB: nAluOp = mipsPkg::ALU_SUB;
					mipsPkg::FN_AND: nAluOp = mipsPkg::ALU_AND;
					mipsPkg::FN_OR: nAluOp = mipsPkg::ALU_OR;
					mipsPkg::FN_XOR: nAluOp = mipsPkg::ALU_XOR;
					mipsPkg::FN_NOR: nAluOp = mipsPkg::ALU_NOR;
					mipsPkg::FN_SLT: nAluOp = mipsPkg::ALU_SLT;
					mipsPkg::FN_SLLV: nAluOp = mipsPkg::ALU_SLL;
					mipsPkg::FN_SRLV: nAluOp = mipsPkg::ALU_SRL;
					mipsPkg::FN_SRAV: nAluOp = mipsPkg::ALU_SRA;
					mipsPkg::FN_SLL:
					begin
						nAluOp = mipsPkg::ALU_SLL;
						nAluSrc = mipsPkg::SRC_SHAMT;
					end
					mipsPkg::FN_SRL:
					begin
						nAluOp = mipsPkg::ALU_SRL;
						nAluSrc = mipsPkg::SRC_SHAMT;
					end
					mipsPkg::FN_SRA:
					begin
						nAluOp = mipsPkg::ALU_SRA;
						nAluSrc = mipsPkg::SRC_SHAMT;
					end
					default: known = 1'b0;          // Unsupported funct is a bubble
				endcase
			end
			mipsPkg::OP_ADDI: nAluOp = mipsPkg::ALU_ADD;
			mipsPkg::OP_SLTI: nAluOp = mipsPkg::ALU_SLT;
			mipsPkg::OP_ANDI:
			begin
				nAluOp = mipsPkg::ALU_AND;
				zeroExt = 1'b1;
			end
			mipsPkg::OP_ORI:
			begin
				nAluOp = mipsPkg::ALU_OR;
				zeroExt = 1'b1;
			end
			mipsPkg::OP_XORI:
			begin
				nAluOp = mipsPkg::ALU_XOR;
				zeroExt = 1'b1;
			end
			mipsPkg::OP_LUI:
			begin
				nAluOp = mipsPkg::ALU_SLL;         // Immediate shifted up by 16
				nAluSrc = mipsPkg::SRC_IMMSHAMT;
				isLui = 1'b1;
			end
			mipsPkg::OP_LB, mipsPkg::OP_LBU,
			mipsPkg::OP_LH, mipsPkg::OP_LHU,
			mipsPkg::OP_LW, mipsPkg::OP_LWU:
			begin
				nMemToReg = 1'b1;
				nLoadUnsigned = opcode[2];
				nReadBytes = sizeMask(opcode[1:0]);
			end
			mipsPkg::OP_SB, mipsPkg::OP_SH, mipsPkg::OP_SW:
			begin
				nRegWrite = 1'b0;
				nMemWrite = 1'b1;
				nWriteBytes = sizeMask(opcode[1:0]);
			end
			mipsPkg::OP_BEQ, mipsPkg::OP_BNE:
			begin
				nRegWrite = 1'b0;
				nBranch = 1'b1;
				nBranchNe = opcode[0];             // Set for BNE
				nAluOp = mipsPkg::ALU_SUB;         // Compare rs with rt
				nAluSrc = mipsPkg::SRC_REG;
			end
			default: known = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Stage register
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst || !instrValid || !known)
		begin
			aluOp <= mipsPkg::ALU_ADD;           // Inactive control set
			aluSrc <= mipsPkg::SRC_REG;
			regWrite <= 1'b0;
			memToReg <= 1'b0;
			memWrite <= 1'b0;
			branch <= 1'b0;
			branchNe <= 1'b0;
			loadUnsigned <= 1'b0;
			readBytes <= mipsPkg::BYTES_W;
			writeBytes <= mipsPkg::BYTES_W;
			destReg <= '0;
		end
		else
		begin
			aluOp <= nAluOp;
			aluSrc <= nAluSrc;
			regWrite <= nRegWrite && (nDest != '0);  // Writes to r0 vanish here
			memToReg <= nMemToReg;
			memWrite <= nMemWrite;
			branch <= nBranch;
			branchNe <= nBranchNe;
			loadUnsigned <= nLoadUnsigned;
			readBytes <= nReadBytes;
			writeBytes <= nWriteBytes;
			destReg <= nDest;
		end
	end

	always_ff @(posedge clk)
	begin
		immVal <= zeroExt ? {16'b0, immField} : {{16{immField[15]}}, immField};
		shamt <= isLui ? 5'd16 : instr[10:6];
	end

	// A store never also writes back
	noDualWrite: assert property (@(posedge clk) disable iff (rst)
		!(regWrite && memWrite))
		else $error("controlDecode: regWrite and memWrite both set");

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input wire clk,
	input wire rst,
	input wire mipsPkg::regAddrT addrA,      // rs field
	input wire mipsPkg::regAddrT addrB,      // rt field
	input wire mipsPkg::regAddrT writeAddr,  // From the executing instruction
	input wire writeEn,
	input wire mipsPkg::wordT writeData,
	output mipsPkg::wordT regA,
	output mipsPkg::wordT regB
);

	mipsPkg::wordT regs [32];               // Architectural registers
	logic wrLive;                           // Write taking effect this edge

	assign wrLive = writeEn && !rst;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (writeEn)
			regs[writeAddr] <= writeData;
	end

	// Registered reads with same-edge write forwarding
	always_ff @(posedge clk)
	begin
		regA <= (wrLive && addrA == writeAddr) ? writeData : regs[addrA];
		regB <= (wrLive && addrB == writeAddr) ? writeData : regs[addrB];
	end

	// r0 is filtered in the decoder
	noZeroWrite: assert property (@(posedge clk) disable iff (rst)
		writeEn |-> writeAddr != '0)
		else $error("regFile: write to register 0");

endmodule

`default_nettype wire

/* aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	input wire mipsPkg::aluOpT aluOp,
	input wire mipsPkg::aluSrcT aluSrc,
	input wire mipsPkg::wordT regA,          // Operand A, rs
	input wire mipsPkg::wordT regB,          // rt
	input wire mipsPkg::wordT immVal,        // Extended immediate
	input wire mipsPkg::shamtT shamt,        // Shamt field or 16 for LUI
	input wire branch,
	input wire branchNe,
	output mipsPkg::wordT aluResult,
	output logic branchTaken
);

	mipsPkg::wordT opB;                     // Selected operand B
	mipsPkg::shamtT shiftAmt;               // Selected shift amount
	logic isZero;                           // Difference for branches

	assign opB = aluSrc[0] ? immVal : regB;
	assign shiftAmt = aluSrc[1] ? shamt : regA[4:0];

	always_comb
	begin
		case (aluOp)
			mipsPkg::ALU_ADD: aluResult = regA + opB;
			mipsPkg::ALU_SUB: aluResult = regA - opB;
			mipsPkg::ALU_AND: aluResult = regA & opB;
			mipsPkg::ALU_OR: aluResult = regA | opB;
			mipsPkg::ALU_XOR: aluResult = regA ^ opB;
			mipsPkg::ALU_NOR: aluResult = ~(regA | opB);
			mipsPkg::ALU_SLL: aluResult = opB << shiftAmt;       // Shifts act on B
			mipsPkg::ALU_SRL: aluResult = opB >> shiftAmt;
			mipsPkg::ALU_SRA: aluResult = $signed(opB) >>> shiftAmt;
			mipsPkg::ALU_SLT: aluResult = {31'b0, $signed(regA) < $signed(opB)};
			default: aluResult = '0;
		endcase
	end

	// BEQ on zero difference, BNE on nonzero
	assign isZero = (aluResult == '0);
	assign branchTaken = branch && (branchNe ? !isZero : isZero);

	// Decoder must hand a defined code to a branch
	always_comb
	begin
		if (branch)
			assert final (aluOp <= mipsPkg::ALU_SLT)
			else $error("aluUnit: undefined aluOp on branch");
	end

endmodule

`default_nettype wire

/* memAccess.sv */
`timescale 1ns/1ps
`default_nettype none

module memAccess (
	input wire clk,
	input wire mipsPkg::wordT aluResult,     // Byte address or ALU value
	input wire mipsPkg::wordT storeData,     // rt value
	input wire memWrite,
	input wire memToReg,
	input wire loadUnsigned,
	input wire mipsPkg::byteMaskT readBytes,
	input wire mipsPkg::byteMaskT writeBytes,
	output mipsPkg::wordT wbData
);

	mipsPkg::wordT mem [mipsPkg::MEM_WORDS];  // Data memory

	logic [mipsPkg::MEM_ADDR_BITS-1:0] wordAddr;
	logic [1:0] byteSel;                    // Lane of the first byte
	mipsPkg::byteMaskT laneMask;            // Lanes written by a store
	mipsPkg::wordT storeLanes;              // Store data moved to its lanes
	mipsPkg::wordT laneData;                // Loaded word moved to lane 0
	mipsPkg::wordT loadVal;                 // Sized and extended load
	mipsPkg::byteMaskT accessBytes;
	logic misaligned;

	assign wordAddr = aluResult[mipsPkg::MEM_ADDR_BITS+1:2];
	assign byteSel = aluResult[1:0];

	////////////////////////////////////////////////////////////////////////////
	// Store path
	////////////////////////////////////////////////////////////////////////////
	assign laneMask = writeBytes << byteSel;
	assign storeLanes = storeData << {byteSel, 3'b000};

	always_ff @(posedge clk)
	begin
		if (memWrite)
		begin
			for (int i = 0; i < 4; i++)
			begin
				if (laneMask[i])
					mem[wordAddr][i*8 +: 8] <= storeLanes[i*8 +: 8];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Load path and writeback select
	////////////////////////////////////////////////////////////////////////////
	assign laneData = mem[wordAddr] >> {byteSel, 3'b000};

	always_comb
	begin
		case (readBytes)
			mipsPkg::BYTES_B: loadVal = {{24{laneData[7] & !loadUnsigned}}, laneData[7:0]};
			mipsPkg::BYTES_H: loadVal = {{16{laneData[15] & !loadUnsigned}}, laneData[15:0]};
			default: loadVal = laneData;         // LW and LWU alike
		endcase
	end

	assign wbData = memToReg ? loadVal : aluResult;

	assign accessBytes = memWrite ? writeBytes : readBytes;
	assign misaligned = (accessBytes == mipsPkg::BYTES_H && byteSel[0])
		|| (accessBytes == mipsPkg::BYTES_W && byteSel != 2'b00);

	alignedAccess: assert property (@(posedge clk)
		(memWrite || memToReg) |-> !misaligned)
		else $error("memAccess: misaligned access at %h", aluResult);

endmodule

`default_nettype wire

/* execCore.sv */
`timescale 1ns/1ps
`default_nettype none

module execCore (
	input wire clk,
	input wire rst,
	input wire mipsPkg::wordT instr,         // Instruction word
	input wire instrValid,                  // Issue strobe
	output wire wbEn,                       // Register write this cycle
	output wire mipsPkg::regAddrT wbReg,
	output wire mipsPkg::wordT wbData,
	output wire branchTaken                 // Branch outcome pulse
);

	// Stage-2 controls
	mipsPkg::aluOpT aluOp;
	mipsPkg::aluSrcT aluSrc;
	logic regWrite;
	logic memToReg;
	logic memWrite;
	logic branch;
	logic branchNe;
	logic loadUnsigned;
	mipsPkg::byteMaskT readBytes;
	mipsPkg::byteMaskT writeBytes;
	mipsPkg::regAddrT destReg;
	mipsPkg::wordT immVal;
	mipsPkg::shamtT shamt;

	// Datapath
	mipsPkg::wordT regA;
	mipsPkg::wordT regB;
	mipsPkg::wordT aluResult;

	controlDecode decode_i (
		.clk(clk),
		.rst(rst),
		.instrValid(instrValid),
		.instr(instr),
		.aluOp(aluOp),
		.aluSrc(aluSrc),
		.regWrite(regWrite),
		.memToReg(memToReg),
		.memWrite(memWrite),
		.branch(branch),
		.branchNe(branchNe),
		.loadUnsigned(loadUnsigned),
		.readBytes(readBytes),
		.writeBytes(writeBytes),
		.destReg(destReg),
		.immVal(immVal),
		.shamt(shamt)
	);

	regFile regs_i (
		.clk(clk),
		.rst(rst),
		.addrA(instr[25:21]),                 // rs
		.addrB(instr[20:16]),                 // rt
		.writeAddr(destReg),
		.writeEn(regWrite),
		.writeData(wbData),
		.regA(regA),
		.regB(regB)
	);

	aluUnit alu_i (
		.aluOp(aluOp),
		.aluSrc(aluSrc),
		.regA(regA),
		.regB(regB),
		.immVal(immVal),
		.shamt(shamt),
		.branch(branch),
		.branchNe(branchNe),
		.aluResult(aluResult),
		.branchTaken(branchTaken)
	);

	memAccess mem_i (
		.clk(clk),
		.aluResult(aluResult),
		.storeData(regB),
		.memWrite(memWrite),
		.memToReg(memToReg),
		.loadUnsigned(loadUnsigned),
		.readBytes(readBytes),
		.writeBytes(writeBytes),
		.wbData(wbData)
	);

	assign wbEn = regWrite;                 // Already low for r0
	assign wbReg = destReg;

endmodule

`default_nettype wire

/* execCoreTb.sv */
`timescale 1ns/1ps
`default_nettype none

module execCoreTb;

	localparam int CYCLE_LIMIT = 2000;      // Roughly 350 issues, reset and idles, 5x margin

	logic clk;
	logic rst;
	mipsPkg::wordT instr;
	logic instrValid;
	wire wbEn;
	wire mipsPkg::regAddrT wbReg;
	wire mipsPkg::wordT wbData;
	wire branchTaken;

	mipsPkg::wordT modelReg [32];           // Architectural register image
	logic [7:0] modelMem [256];             // Byte image of data memory
	logic expWe;                            // Expected outputs of the issued instruction
	mipsPkg::regAddrT expReg;
	mipsPkg::wordT expData;
	logic expBr;
	int storeLen;                           // Bytes of a pending store
	logic [7:0] storeAddr;
	mipsPkg::wordT storeVal;
	string testName;
	int cycleCount;

	execCore dut_i (
		.clk(clk),
		.rst(rst),
		.instr(instr),
		.instrValid(instrValid),
		.wbEn(wbEn),
		.wbReg(wbReg),
		.wbData(wbData),
		.branchTaken(branchTaken)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;                // 4 ns period
	end

	////////////////////////////////////////////////////////////////////////////
	// Instruction encoding
	////////////////////////////////////////////////////////////////////////////
	function automatic mipsPkg::wordT rTypeWord(input mipsPkg::functT fn,
		input mipsPkg::regAddrT rs, input mipsPkg::regAddrT rt,
		input mipsPkg::regAddrT rd, input mipsPkg::shamtT sh);
		rTypeWord = {mipsPkg::OP_RTYPE, rs, rt, rd, sh, fn};
	endfunction

	function automatic mipsPkg::wordT immWord(input mipsPkg::opcodeT op,
		input mipsPkg::regAddrT rs, input mipsPkg::regAddrT rt, input logic [15:0] imm);
		immWord = {op, rs, rt, imm};
	endfunction

	function automatic mipsPkg::wordT branchWord(input logic ne,
		input mipsPkg::regAddrT rs, input mipsPkg::regAddrT rt);
		branchWord = {ne ? mipsPkg::OP_BNE : mipsPkg::OP_BEQ, rs, rt, 16'h0010};  // Offset unused
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////
	function automatic mipsPkg::wordT loadLanes(input logic [7:0] addr, input int n);
		mipsPkg::wordT v;
		v = '0;
		for (int i = 0; i < n; i++)
			v[i*8 +: 8] = modelMem[addr + i[7:0]];  // Little-endian
		return v;
	endfunction

	task automatic predict(input mipsPkg::wordT ins);
		mipsPkg::opcodeT op;
		mipsPkg::regAddrT dst;
		mipsPkg::shamtT sh;
		mipsPkg::wordT a;
		mipsPkg::wordT b;
		mipsPkg::wordT sImm;
		mipsPkg::wordT zImm;
		mipsPkg::wordT addr;
		mipsPkg::wordT lv;
		op = ins[31:26];
		sh = ins[10:6];
		a = modelReg[ins[25:21]];
		b = modelReg[ins[20:16]];
		sImm = {{16{ins[15]}}, ins[15:0]};
		zImm = {16'b0, ins[15:0]};
		addr = a + sImm;
		dst = ins[20:16];                     // rt unless R-type
		expWe = 1'b1;
		expData = '0;
		expBr = 1'b0;
		storeLen = 0;
		storeAddr = addr[7:0];
		storeVal = b;
		case (op)
			mipsPkg::OP_RTYPE:
			begin
				dst = ins[15:11];
				case (ins[5:0])
					mipsPkg::FN_ADD: expData = a + b;
					mipsPkg::FN_SUB: expData = a - b;
					mipsPkg::FN_AND: expData = a & b;
					mipsPkg::FN_OR: expData = a | b;
					mipsPkg::FN_XOR: expData = a ^ b;
					mipsPkg::FN_NOR: expData = ~(a | b);
					mipsPkg::FN_SLT: expData = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					mipsPkg::FN_SLL: expData = b << sh;
					mipsPkg::FN_SRL: expData = b >> sh;
					mipsPkg::FN_SRA: expData = $signed(b) >>> sh;
					mipsPkg::FN_SLLV: expData = b << a[4:0];
					mipsPkg::FN_SRLV: expData = b >> a[4:0];
					mipsPkg::FN_SRAV: expData = $signed(b) >>> a[4:0];
					default: expWe = 1'b0;        // Bubble
				endcase
			end
			mipsPkg::OP_ADDI: expData = a + sImm;
			mipsPkg::OP_SLTI: expData = ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
			mipsPkg::OP_ANDI: expData = a & zImm;
			mipsPkg::OP_ORI: expData = a | zImm;
			mipsPkg::OP_XORI: expData = a ^ zImm;
			mipsPkg::OP_LUI: expData = {ins[15:0], 16'b0};
			mipsPkg::OP_LB:
			begin
				lv = loadLanes(addr[7:0], 1);
				expData = {{24{lv[7]}}, lv[7:0]};
			end
			mipsPkg::OP_LBU: expData = loadLanes(addr[7:0], 1);
			mipsPkg::OP_LH:
			begin
				lv = loadLanes(addr[7:0], 2);
				expData = {{16{lv[15]}}, lv[15:0]};
			end
			mipsPkg::OP_LHU: expData = loadLanes(addr[7:0], 2);
			mipsPkg::OP_LW, mipsPkg::OP_LWU: expData = loadLanes(addr[7:0], 4);
			mipsPkg::OP_SB, mipsPkg::OP_SH, mipsPkg::OP_SW:
			begin
				expWe = 1'b0;
				storeLen = (op == mipsPkg::OP_SB) ? 1 : (op == mipsPkg::OP_SH) ? 2 : 4;
			end
			mipsPkg::OP_BEQ, mipsPkg::OP_BNE:
			begin
				expWe = 1'b0;
				expBr = (op == mipsPkg::OP_BNE) ? (a != b) : (a == b);
			end
			default: expWe = 1'b0;              // Unknown opcode
		endcase
		if (dst == 5'd0)
			expWe = 1'b0;                       // r0 is never written
		expReg = dst;
	endtask

	task automatic commitModel();
		if (expWe)
			modelReg[expReg] = expData;
		for (int i = 0; i < storeLen; i++)
			modelMem[storeAddr + i[7:0]] = storeVal[i*8 +: 8];
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Drive and check
	////////////////////////////////////////////////////////////////////////////
	task automatic failRun();
		$display("FAIL: see errors above");
		$fatal(1, "execCoreTb stopped at first error");
	endtask

	task automatic checkValue(input string what, input mipsPkg::wordT exp,
		input mipsPkg::wordT act);
		assert (act === exp)
		else
		begin
			$display("ERROR %s %s expected %h actual %h", testName, what, exp, act);
			failRun();
		end
	endtask

	// One instruction in, its results one cycle later
	task automatic issue(input mipsPkg::wordT ins);
		predict(ins);
		instr = ins;
		instrValid = 1'b1;
		@(posedge clk);
		#1;
		instrValid = 1'b0;                    // Next issue may raise it again at once
		checkValue("wbEn", {31'b0, expWe}, {31'b0, wbEn});
		checkValue("branchTaken", {31'b0, expBr}, {31'b0, branchTaken});
		if (expWe)
		begin
			checkValue("wbReg", {27'b0, expReg}, {27'b0, wbReg});
			checkValue("wbData", expData, wbData);
		end
		commitModel();
	endtask

	task automatic setReg(input mipsPkg::regAddrT r, input mipsPkg::wordT v);
		issue(immWord(mipsPkg::OP_LUI, 5'd0, r, v[31:16]));
		issue(immWord(mipsPkg::OP_ORI, r, r, v[15:0]));  // Dependent, bypassed
	endtask

	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
			checkValue("idle wbEn", 32'd0, {31'b0, wbEn});
			checkValue("idle branchTaken", 32'd0, {31'b0, branchTaken});
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////
	task automatic afterReset();
		testName = "reset";
		checkValue("wbEn", 32'd0, {31'b0, wbEn});
		checkValue("branchTaken", 32'd0, {31'b0, branchTaken});
		issue(rTypeWord(mipsPkg::FN_ADD, 5'd0, 5'd0, 5'd1, 5'd0));  // r1 = r0 + r0
	endtask

	task automatic registerOps();
		mipsPkg::functT fns [13];
		mipsPkg::wordT va;
		mipsPkg::wordT vb;
		mipsPkg::wordT rnd;
		mipsPkg::shamtT sh;
		fns = '{mipsPkg::FN_ADD, mipsPkg::FN_SUB, mipsPkg::FN_AND, mipsPkg::FN_OR,
			mipsPkg::FN_XOR, mipsPkg::FN_NOR, mipsPkg::FN_SLT, mipsPkg::FN_SLL,
			mipsPkg::FN_SRL, mipsPkg::FN_SRA, mipsPkg::FN_SLLV, mipsPkg::FN_SRLV,
			mipsPkg::FN_SRAV};
		testName = "rtype";
		for (int k = 0; k < 8; k++)
		begin
			va = $urandom();
			vb = $urandom();
			rnd = $urandom();
			sh = rnd[4:0];
			if (k < 2)
			begin
				sh = (k == 0) ? 5'd0 : 5'd31;     // Edge shift amounts
				va[4:0] = sh;
			end
			setReg(5'd1, va);
			setReg(5'd2, vb);
			foreach (fns[j])
				issue(rTypeWord(fns[j], 5'd1, 5'd2, 5'd3, sh));
		end
	endtask

	task automatic immediateOps();
		mipsPkg::wordT va;
		mipsPkg::wordT rnd;
		testName = "immediate";
		for (int k = 0; k < 6; k++)
		begin
			va = $urandom();
			rnd = $urandom();
			setReg(5'd4, va);
			issue(immWord(mipsPkg::OP_ADDI, 5'd4, 5'd5, {1'b1, rnd[14:0]}));  // Negative
			issue(immWord(mipsPkg::OP_SLTI, 5'd4, 5'd6, {1'b1, rnd[30:16]}));
			issue(immWord(mipsPkg::OP_ANDI, 5'd4, 5'd7, rnd[15:0] | 16'h8000));  // Top bit set
			issue(immWord(mipsPkg::OP_ORI, 5'd4, 5'd7, rnd[31:16] | 16'h8000));
			issue(immWord(mipsPkg::OP_XORI, 5'd4, 5'd7, rnd[23:8] | 16'h8000));
			issue(immWord(mipsPkg::OP_LUI, 5'd0, 5'd9, rnd[15:0]));
		end
	endtask

	task automatic memoryOps();
		mipsPkg::wordT v;
		mipsPkg::wordT base;
		testName = "memory";
		for (int k = 0; k < 3; k++)
		begin
			base = 32'h20 + 32'(k) * 32'h40;   // Disjoint regions per pass
			v = $urandom();
			if (k == 0)
				v = v | 32'h80808080;             // Sign bit in every lane
			if (k == 1)
				v = v & 32'h7f7f7f7f;
			issue(immWord(mipsPkg::OP_ADDI, 5'd0, 5'd8, base[15:0]));
			setReg(5'd9, v);
			issue(immWord(mipsPkg::OP_SW, 5'd8, 5'd9, 16'd0));
			issue(immWord(mipsPkg::OP_SH, 5'd8, 5'd9, 16'd6));
			issue(immWord(mipsPkg::OP_SB, 5'd8, 5'd9, 16'd9));
			issue(immWord(mipsPkg::OP_SB, 5'd8, 5'd9, 16'hfffb));  // Offset -5
			issue(immWord(mipsPkg::OP_LW, 5'd8, 5'd10, 16'd0));
			issue(immWord(mipsPkg::OP_LWU, 5'd8, 5'd11, 16'd0));
			for (int off = 0; off < 4; off++)
			begin
				issue(immWord(mipsPkg::OP_LB, 5'd8, 5'd10, off[15:0]));
				issue(immWord(mipsPkg::OP_LBU, 5'd8, 5'd11, off[15:0]));
				if (off[0] == 1'b0)
				begin
					issue(immWord(mipsPkg::OP_LH, 5'd8, 5'd10, off[15:0]));
					issue(immWord(mipsPkg::OP_LHU, 5'd8, 5'd11, off[15:0]));
				end
			end
			issue(immWord(mipsPkg::OP_LH, 5'd8, 5'd10, 16'd6));
			issue(immWord(mipsPkg::OP_LHU, 5'd8, 5'd11, 16'd6));
			issue(immWord(mipsPkg::OP_LB, 5'd8, 5'd10, 16'd9));
			issue(immWord(mipsPkg::OP_LBU, 5'd8, 5'd11, 16'hfffb));
			v = $urandom();
			setReg(5'd12, v);
			issue(immWord(mipsPkg::OP_SB, 5'd8, 5'd12, 16'd1));  // Merge into stored word
			issue(immWord(mipsPkg::OP_LW, 5'd8, 5'd10, 16'd0));
			issue(immWord(mipsPkg::OP_SH, 5'd8, 5'd12, 16'd2));
			issue(immWord(mipsPkg::OP_LW, 5'd8, 5'd10, 16'd0));
		end
	endtask

	task automatic branchOps();
		mipsPkg::wordT va;
		mipsPkg::wordT vb;
		testName = "branch";
		for (int k = 0; k < 4; k++)
		begin
			va = $urandom();
			vb = $urandom();
			if (k == 3)
				vb = va;                          // Equal values, different registers
			setReg(5'd1, va);
			setReg(5'd2, vb);
			issue(branchWord(1'b0, 5'd1, 5'd2));
			issue(branchWord(1'b1, 5'd1, 5'd2));
			issue(branchWord(1'b0, 5'd1, 5'd1));
			issue(branchWord(1'b1, 5'd1, 5'd1));
		end
	endtask

	task automatic bypassAndBubbles();
		testName = "bypass";
		issue(immWord(mipsPkg::OP_ADDI, 5'd0, 5'd3, 16'h1234));
		issue(immWord(mipsPkg::OP_ADDI, 5'd3, 5'd3, 16'hff00));  // Reads r3 just written
		issue(rTypeWord(mipsPkg::FN_ADD, 5'd3, 5'd3, 5'd4, 5'd0));
		issue(rTypeWord(mipsPkg::FN_SUB, 5'd4, 5'd3, 5'd5, 5'd0));
		issue(immWord(mipsPkg::OP_SW, 5'd0, 5'd5, 16'h00f0));
		issue(immWord(mipsPkg::OP_LW, 5'd0, 5'd6, 16'h00f0));  // Store then load at once
		issue(rTypeWord(mipsPkg::FN_ADD, 5'd6, 5'd6, 5'd7, 5'd0));  // Load result used
		testName = "r0";
		issue(immWord(mipsPkg::OP_ADDI, 5'd5, 5'd0, 16'h0005));
		issue(rTypeWord(mipsPkg::FN_ADD, 5'd0, 5'd0, 5'd8, 5'd0));
		testName = "bubble";
		idleCycles(3);
		issue({6'b111111, 5'd5, 5'd7, 16'h4321});  // Unknown opcode
		issue(rTypeWord(6'b001000, 5'd5, 5'd6, 5'd7, 5'd0));  // Unsupported funct
		idleCycles(2);
		issue(rTypeWord(mipsPkg::FN_ADD, 5'd7, 5'd0, 5'd9, 5'd0));  // r7 untouched
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Run control
	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		cycleCount = 0;
		while (cycleCount < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		failRun();
	end

	initial
	begin
		void'($urandom(32'h84f9));
		rst = 1'b1;
		instr = '0;
		instrValid = 1'b0;
		testName = "init";
		for (int i = 0; i < 32; i++)
			modelReg[i] = '0;                   // Cleared by reset
		for (int i = 0; i < 256; i++)
			modelMem[i] = 8'h00;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		afterReset();
		registerOps();
		immediateOps();
		memoryOps();
		branchOps();
		bypassAndBubbles();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
mipsPkg.sv
controlDecode.sv
regFile.sv
aluUnit.sv
memAccess.sv
execCore.sv
execCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the execCore testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module execCoreTb -f verilog.f -o execCoreSim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/execCoreSim
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi

exit 0
